// ==== src/armIsaPkg.sv ====
`default_nettype none

package armIsaPkg;

	// data-processing opcodes in instruction bit order 24:21
	// the ALU takes the same code
	typedef enum logic [3:0] {
		AND = 4'h0,
		EOR = 4'h1,
		SUB = 4'h2,
		RSB = 4'h3,
		ADD = 4'h4,
		ADC = 4'h5,
		SBC = 4'h6,
		RSC = 4'h7,
		TST = 4'h8,
		TEQ = 4'h9,
		CMP = 4'ha,
		CMN = 4'hb,
		ORR = 4'hc,
		MOV = 4'hd,
		BIC = 4'he,
		MVN = 4'hf
	} dpOpcode;

	// 0..3 follow the instruction's shift field
	typedef enum logic [2:0] {
		LSL  = 3'h0,
		LSR  = 3'h1,
		ASR  = 3'h2,
		ROR  = 3'h3,
		RRX  = 3'h4, // ROR with amount 0
		PASS = 3'h5  // operand goes through untouched
	} shiftType;

	// 4'b1111 has no name here, the checker treats it as never
	typedef enum logic [3:0] {
		EQ = 4'h0,
		NE = 4'h1,
		CS = 4'h2,
		CC = 4'h3,
		MI = 4'h4,
		PL = 4'h5,
		VS = 4'h6,
		VC = 4'h7,
		HI = 4'h8,
		LS = 4'h9,
		GE = 4'ha,
		LT = 4'hb,
		GT = 4'hc,
		LE = 4'hd,
		AL = 4'he
	} condCode;

	// bit positions inside NZCV
	localparam int flagNeg = 3;
	localparam int flagZer = 2;
	localparam int flagCar = 1;
	localparam int flagOvf = 0;

	localparam logic [3:0] pcReg = 4'd15; // r15 is the PC

endpackage

`default_nettype wire

// ==== src/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	// access size seen by the data memory
	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10
	} memWidth;

	// how the extender builds the immediate
	typedef enum logic [1:0] {
		IMM8ROT   = 2'b00, // data processing, imm8 with rotate
		IMM12     = 2'b01, // LDR/STR offset
		IMM24     = 2'b10, // branch offset
		IMMSPLIT8 = 2'b11  // halfword forms, bits 11:8 and 3:0
	} immSrcSel;

	localparam int memSelectW = 3; // {signed, memWidth}
	localparam int regSrcW = 2;

	// regSrc bit 0 reads r15 as Rn, bit 1 reads Rd as the second operand
	localparam logic [regSrcW-1:0] regSrcPc = 2'b01;
	localparam logic [regSrcW-1:0] regSrcStore = 2'b10;

endpackage

`default_nettype wire

// ==== src/condCheck.sv ====
`timescale 1ns/10ps
`default_nettype none

module condCheck
	import armIsaPkg::*;
(
	input  condCode    cond,
	input  logic [3:0] flags, // NZCV
	output logic       condEx
);

	logic neg;
	logic zer;
	logic car;
	logic ovf;
	logic ge; // N == V

	assign neg = flags[flagNeg];
	assign zer = flags[flagZer];
	assign car = flags[flagCar];
	assign ovf = flags[flagOvf];
	assign ge  = ~(neg ^ ovf);

	always_comb begin
		case (cond)
			EQ: condEx = zer;
			NE: condEx = ~zer;
			CS: condEx = car;
			CC: condEx = ~car;
			MI: condEx = neg;
			PL: condEx = ~neg;
			VS: condEx = ovf;
			VC: condEx = ~ovf;
			HI: condEx = car & ~zer;
			LS: condEx = ~car | zer;
			GE: condEx = ge;
			LT: condEx = ~ge;
			GT: condEx = ~zer & ge;
			LE: condEx = zer | ~ge;
			AL: condEx = 1'b1;
			default: condEx = 1'b0; // 4'b1111, never
		endcase
	end

endmodule

`default_nettype wire

// ==== src/condLogic.sv ====
`timescale 1ns/10ps
`default_nettype none

module condLogic
	import armIsaPkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  condCode    cond,
	input  logic [3:0] flagW,
	input  logic       pcs,
	input  logic       regW,
	input  logic       memW,
	input  logic [3:0] aluFlags, // NZCV of the current instruction
	output logic       pcSrc,
	output logic       regWrite,
	output logic       memWrite
);

	logic [3:0] flags;     // stored NZCV
	logic [3:0] flagWrite; // mask after condition
	logic condEx;

	condCheck condCheck_i (
		.cond   (cond),
		.flags  (flags),
		.condEx (condEx)
	);

	assign flagWrite = flagW & {4{condEx}};

	// each flag loads on its own enable
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else begin
			flags <= (flags & ~flagWrite) | (aluFlags & flagWrite);
		end
	end

	// a failed condition turns the instruction into a no-op
	assign pcSrc    = pcs & condEx;
	assign regWrite = regW & condEx;
	assign memWrite = memW & condEx;

	// unwritten flags hold across the edge
	assert property (@(posedge clk) disable iff (!rstN)
		flagWrite == 4'b0000 |=> flags == $past(flags))
		else $error("condLogic: flags changed without a write");

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder
	import armIsaPkg::*;
	import ctrlPkg::*;
(
	input  logic [1:0]            op,
	input  logic [5:0]            funct,
	input  logic [3:0]            rd,
	input  logic [11:4]           instrMid,
	output logic [3:0]            flagW, // per-flag write mask, NZCV
	output logic                  pcs,
	output logic                  regW,
	output logic                  memW,
	output logic                  memToReg,
	output logic                  aluSrc,
	output logic                  linkSelect,
	output immSrcSel              immSrc,
	output logic [regSrcW-1:0]    regSrc,
	output dpOpcode               aluControl,
	output shiftType              shiftOp,
	output logic                  registerShift,
	output logic [memSelectW-1:0] memSelect
);

	logic branch;
	logic aluOp;      // data processing, ALU decoder takes funct
	logic regWRaw;    // before masking of compares
	logic isCompare;
	logic loadSigned;
	memWidth width;
	logic extraMem;   // halfword and signed loads/stores
	dpOpcode opc;

	assign opc = dpOpcode'(funct[4:1]);

	// bits 7 and 4 both set in the register space of op 00
	assign extraMem = ~funct[5] & instrMid[7] & instrMid[4];

	// shift amount comes from Rs
	assign registerShift = (op == 2'b00) & ~funct[5] & instrMid[4] & ~instrMid[7];

	assign memSelect = {loadSigned, width};

	// main decoder
	always_comb begin
		regSrc     = '0;
		immSrc     = IMM8ROT;
		aluSrc     = 1'b0;
		memToReg   = 1'b0;
		regWRaw    = 1'b0;
		memW       = 1'b0;
		branch     = 1'b0;
		aluOp      = 1'b0;
		linkSelect = 1'b0;
		isCompare  = 1'b0;
		shiftOp    = PASS;
		loadSigned = 1'b0;
		width      = WORD;
		case (op)
			2'b00: begin
				if (extraMem) begin
					immSrc = IMMSPLIT8;
					aluSrc = 1'b1;
					if (instrMid[5]) begin // LDRH, STRH, LDRSH
						width      = HALF;
						loadSigned = instrMid[6];
					end else begin // SH = 10, LDRSB
						width      = BYTE;
						loadSigned = 1'b1;
					end
					if (funct[0]) begin
						memToReg = 1'b1;
						regWRaw  = 1'b1;
					end else begin
						memW   = 1'b1;
						regSrc = regSrcStore;
					end
				end else begin
					aluOp     = 1'b1;
					regWRaw   = 1'b1;
					isCompare = (funct[4:3] == 2'b10); // TST TEQ CMP CMN
					if (funct[5]) begin
						aluSrc  = 1'b1;
						shiftOp = ROR; // imm8 rotated right by 2*rot
					end else if (instrMid[11:7] == 5'd0 && !instrMid[4] &&
							instrMid[6:5] == 2'b11) begin
						shiftOp = RRX;
					end else begin
						shiftOp = shiftType'({1'b0, instrMid[6:5]});
					end
				end
			end
			2'b01: begin
				immSrc = IMM12;
				aluSrc = 1'b1;
				width  = funct[2] ? BYTE : WORD; // B bit
				if (funct[0]) begin // load
					memToReg = 1'b1;
					regWRaw  = 1'b1;
				end else begin
					memW   = 1'b1;
					regSrc = regSrcStore;
				end
			end
			2'b10: begin
				branch = 1'b1;
				regSrc = regSrcPc;
				immSrc = IMM24;
				aluSrc = 1'b1;
				if (funct[4]) begin // BL writes return address to lr
					regWRaw    = 1'b1;
					linkSelect = 1'b1;
				end
			end
			default: begin
				// coprocessor space, nothing is enabled
			end
		endcase
	end

	// ALU decoder
	always_comb begin
		aluControl = ADD; // address and branch target adds
		flagW      = '0;
		if (aluOp) begin
			aluControl     = opc;
			flagW[flagNeg] = funct[0];
			flagW[flagZer] = funct[0];
			flagW[flagCar] = funct[0];
			case (opc)
				ADD, SUB, RSB, ADC, SBC, RSC: flagW[flagOvf] = funct[0];
				TST, TEQ: begin
					flagW[flagNeg] = 1'b1;
					flagW[flagZer] = 1'b1;
					flagW[flagCar] = 1'b1;
				end
				CMP, CMN: flagW = 4'b1111;
				default: flagW[flagOvf] = 1'b0; // logical ops keep V
			endcase
		end
	end

	assign regW = regWRaw & ~isCompare;

	// PC logic
	assign pcs = branch | (regW & (rd == pcReg));

	always_comb begin
		assert final (!(memW && memToReg))
			else $error("decoder: memW and memToReg high together");
		assert final (!linkSelect || pcs)
			else $error("decoder: linkSelect without pcs");
	end

endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnit
	import armIsaPkg::*;
	import ctrlPkg::*;
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic [31:0]           instr,
	input  logic [3:0]            aluFlags,
	output logic                  pcSrc,
	output logic                  regWrite,
	output logic                  memWrite,
	output logic                  memToReg,
	output logic                  aluSrc,
	output logic                  linkSelect,
	output immSrcSel              immSrc,
	output logic [regSrcW-1:0]    regSrc,
	output dpOpcode               aluControl,
	output shiftType              shiftOp,
	output logic                  registerShift,
	output logic [memSelectW-1:0] memSelect
);

	condCode cond;
	logic [1:0] op;
	logic [5:0] funct;
	logic [3:0] rd;
	logic [11:4] instrMid; // shift and halfword fields
	logic [3:0] flagW;
	logic pcs;
	logic regW;
	logic memW;

	assign cond     = condCode'(instr[31:28]);
	assign op       = instr[27:26];
	assign funct    = instr[25:20];
	assign rd       = instr[15:12];
	assign instrMid = instr[11:4];

	decoder decoder_i (
		.op            (op),
		.funct         (funct),
		.rd            (rd),
		.instrMid      (instrMid),
		.flagW         (flagW),
		.pcs           (pcs),
		.regW          (regW),
		.memW          (memW),
		.memToReg      (memToReg),
		.aluSrc        (aluSrc),
		.linkSelect    (linkSelect),
		.immSrc        (immSrc),
		.regSrc        (regSrc),
		.aluControl    (aluControl),
		.shiftOp       (shiftOp),
		.registerShift (registerShift),
		.memSelect     (memSelect)
	);

	condLogic condLogic_i (
		.clk      (clk),
		.rstN     (rstN),
		.cond     (cond),
		.flagW    (flagW),
		.pcs      (pcs),
		.regW     (regW),
		.memW     (memW),
		.aluFlags (aluFlags),
		.pcSrc    (pcSrc),
		.regWrite (regWrite),
		.memWrite (memWrite)
	);

endmodule

`default_nettype wire

// ==== tests/controlUnitTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnitTb
	import armIsaPkg::*;
	import ctrlPkg::*;
();

	localparam int maxVectors = 128;
	localparam logic [31:0] neverInstr = 32'hf000_0000; // cond 1111 never executes

	logic clk = 1'b0;
	logic rstN;
	logic [31:0] instr;
	logic [3:0] aluFlags;
	logic pcSrc;
	logic regWrite;
	logic memWrite;
	logic memToReg;
	logic aluSrc;
	logic linkSelect;
	immSrcSel immSrc;
	logic [regSrcW-1:0] regSrc;
	dpOpcode aluControl;
	shiftType shiftOp;
	logic registerShift;
	logic [memSelectW-1:0] memSelect;

	// instr, nzcv, then one nibble per expected output
	logic [83:0] vectors [0:maxVectors-1];
	int vectorCount;

	controlUnit controlUnit_i (
		.clk           (clk),
		.rstN          (rstN),
		.instr         (instr),
		.aluFlags      (aluFlags),
		.pcSrc         (pcSrc),
		.regWrite      (regWrite),
		.memWrite      (memWrite),
		.memToReg      (memToReg),
		.aluSrc        (aluSrc),
		.linkSelect    (linkSelect),
		.immSrc        (immSrc),
		.regSrc        (regSrc),
		.aluControl    (aluControl),
		.shiftOp       (shiftOp),
		.registerShift (registerShift),
		.memSelect     (memSelect)
	);

	always #2 clk = ~clk; // 4 ns period

	// left in entries the file does not fill, no real vector has pcSrc f
	function automatic logic [83:0] emptyMarker(input int index);
		return ~84'(index);
	endfunction

	task automatic compareField(input string name, input logic [3:0] expected,
			input logic [3:0] actual, input int index);
		assert (actual === expected) else begin
			$display("error: vector %0d %s expected %h got %h", index, name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic checkOutputs(input int index);
		logic [83:0] v;
		v = vectors[index];
		compareField("pcSrc", v[47:44], {3'b0, pcSrc}, index);
		compareField("regWrite", v[43:40], {3'b0, regWrite}, index);
		compareField("memWrite", v[39:36], {3'b0, memWrite}, index);
		compareField("memToReg", v[35:32], {3'b0, memToReg}, index);
		compareField("aluSrc", v[31:28], {3'b0, aluSrc}, index);
		compareField("linkSelect", v[27:24], {3'b0, linkSelect}, index);
		compareField("immSrc", v[23:20], {2'b0, immSrc}, index);
		compareField("regSrc", v[19:16], {2'b0, regSrc}, index);
		compareField("aluControl", v[15:12], aluControl, index);
		compareField("shiftOp", v[11:8], {1'b0, shiftOp}, index);
		compareField("registerShift", v[7:4], {3'b0, registerShift}, index);
		compareField("memSelect", v[3:0], {1'b0, memSelect}, index);
	endtask

	initial begin
		rstN     = 1'b0;
		instr    = neverInstr;
		aluFlags = 4'h0;

		for (int i = 0; i < maxVectors; i++)
			vectors[i] = emptyMarker(i);
		$readmemh("tests/controlUnitTests.mem", vectors);
		vectorCount = 0;
		while (vectorCount < maxVectors &&
				vectors[vectorCount] !== emptyMarker(vectorCount))
			vectorCount++;
		if (vectorCount == 0) begin
			$display("no test vectors could be read from tests/controlUnitTests.mem");
			$display("SIMULATION FAILED");
			$fatal(1, "empty vector file");
		end

		repeat (8) @(posedge clk);
		rstN <= 1'b1;

		for (int i = 0; i < vectorCount; i++) begin
			@(posedge clk);
			instr    <= vectors[i][83:52];
			aluFlags <= vectors[i][51:48];
			@(negedge clk); // outputs settled mid-cycle
			checkOutputs(i);
		end

		$display("%0d vectors checked", vectorCount);
		$display("SIMULATION PASSED");
		$finish;
	end

	// budget is vectors plus reset plus some slack
	initial begin : watchdog
		int timeoutNs;
		#1;
		timeoutNs = (vectorCount + 8 + 10) * 4;
		#(timeoutNs);
		$display("timeout: the vectors did not finish within %0d ns", timeoutNs);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== compile.f ====
src/armIsaPkg.sv
src/ctrlPkg.sv
src/condCheck.sv
src/condLogic.sv
src/decoder.sv
src/controlUnit.sv
tests/controlUnitTb.sv

// ==== tests/controlUnitTests.mem ====
// instr_nzcv_[pcSrc regWrite memWrite memToReg aluSrc linkSelect]
//   _[immSrc regSrc aluControl shiftOp registerShift memSelect]
// flags are zero after reset, EQ fails and NE passes
0a000002_0_000010_214502
1a000002_0_100010_214502
// data processing, immediate and register forms
e2801005_0_010010_004302
e0812000_0_010000_004002
e2412001_0_010010_002302
e0412000_0_010000_002002
e200100f_0_010010_000302
e0012000_0_010000_000002
e38110ff_0_010010_00c302
e1812000_0_010000_00c002
e3a03001_0_010010_00d302
e1a03002_0_010000_00d002
// TST sets C, then BCS taken
e1110000_2_000000_008002
2a000002_0_100010_214502
// CMP equal, BEQ taken, BNE not
e1510000_4_000000_00a002
0a000002_0_100010_214502
1a000002_0_000010_214502
// CMN sets V, MOVS keeps it, ADDS clears it
e1710000_1_000000_00b002
e3b01000_0_010010_00d302
6a000002_0_100010_214502
e0911000_0_010000_004002
6a000002_0_000010_214502
7a000002_0_100010_214502
// failed condition writes nothing
01510000_4_000000_00a002
0a000002_0_000010_214502
00812000_0_000000_004002
// LDR STR LDRB STRB LDRH STRH LDRSB LDRSH
e5901004_0_010110_104502
e5801004_0_001010_124502
e5d01004_0_010110_104500
e5c01004_0_001010_124500
e1d010b4_0_010110_304501
e1c010b4_0_001010_324501
e1d010d4_0_010110_304504
e1d010f4_0_010110_304505
// B, BL, MOV pc
ea000002_0_100010_214502
eb000002_0_110011_214502
e1a0f00e_0_110000_00d002
// shifts, immediate amount, RRX, register amount, rotated immediate
e0801102_0_010000_004002
e08011a2_0_010000_004102
e08010c2_0_010000_004202
e0801262_0_010000_004302
e0801062_0_010000_004402
e0801312_0_010000_004012
e0801372_0_010000_004312
e2801c01_0_010010_004302
